/* Makefile */
SOURCES = source/readout_defs.svh source/readoutPkg.sv source/resultBuffer.sv \
          source/outputFetch.sv source/bytePairer.sv source/readoutControl.sv \
          source/outputReadout.sv tb/tbOutputReadout.sv

.PHONY: run clean

run: obj_dir/VtbOutputReadout
	./obj_dir/VtbOutputReadout | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "Test passed" sim.log

obj_dir/VtbOutputReadout: files.f $(SOURCES)
	verilator --binary --timing -Wno-fatal -f files.f --top-module tbOutputReadout

clean:
	rm -rf obj_dir sim.log

/* files.f */
+incdir+source
source/readoutPkg.sv
source/resultBuffer.sv
source/outputFetch.sv
source/bytePairer.sv
source/readoutControl.sv
source/outputReadout.sv
tb/tbOutputReadout.sv

/* source/bytePairer.sv */
`default_nettype none

module bytePairer
(
  input  logic             clock,
  input  logic             reset_n,
  input  readoutPkg::byteT byteA,
  input  readoutPkg::byteT byteB,
  input  logic             validA,
  input  logic             validB,
  input  logic             lastA,
  input  logic             lastB,
  output logic             laneTaken,
  output logic [15:0]      outData,
  output logic             outValid,
  output logic             outLast,
  input  logic             outReady,
  output logic             runDone
);

  // Lane B in the high half.
  assign outData = {byteB, byteA};
  assign outValid = validA && validB;
  assign outLast = lastA && lastB;

  // Both lanes advance together on a beat transfer.
  assign laneTaken = outValid && outReady;

  always_ff @(posedge clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      runDone <= 1'b0;
    end
    else
    begin
      runDone <= laneTaken && outLast;  // Pulse after the final beat.
    end
  end

endmodule

`default_nettype wire

/* source/outputFetch.sv */
`default_nettype none

module outputFetch
(
  input  logic                 clock,
  input  logic                 reset_n,
  input  logic                 runStart,
  input  readoutPkg::lengthT    runLength,
  output logic                 readEnable,
  output readoutPkg::bufAddrT   readAddress,
  input  readoutPkg::wordT      readData,
  output readoutPkg::byteT      laneByte,
  output logic                 laneValid,
  output logic                 laneLast,
  input  logic                 laneTaken
);
  import readoutPkg::*;

  fetchStateT state;
  bufAddrT    wordAddr;
  bufAddrT    lastAddr;
  byteIndexT  byteIndex;
  wordT       wordHeld;
  wordT       currentWord;
  logic       loadPending;  // Prefetched word sits on readData.
  logic       lastWord;
  logic       lastByte;

  assign lastWord = (wordAddr == lastAddr);
  assign lastByte = (byteIndex == '1);

  // First read on start, then one prefetch while byte 15 is held.
  assign readEnable = ((state == Idle) && runStart) ||
                      ((state == Emit) && lastByte && !lastWord);
  assign readAddress = (state == Idle) ? '0 : wordAddr + 1'b1;

  assign currentWord = loadPending ? readData : wordHeld;
  assign laneByte = currentWord[byteIndex * $bits(byteT) +: $bits(byteT)];  // Ascending.
  assign laneValid = (state == Emit);
  assign laneLast = laneValid && lastByte && lastWord;

  always_ff @(posedge clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state <= Idle;
      wordAddr <= '0;
      lastAddr <= '0;
      byteIndex <= '0;
      loadPending <= 1'b0;
    end
    else
    begin
      case (state)
        Idle:
        begin
          if (runStart)
          begin
            state <= Read;
            wordAddr <= '0;
            lastAddr <= bufAddrT'(runLength - 1'b1);
            byteIndex <= '0;
          end
        end
        Read:
        begin
          state <= Emit;  // Word lands this cycle.
        end
        Emit:
        begin
          loadPending <= 1'b0;
          if (laneTaken)
          begin
            if (!lastByte)
            begin
              byteIndex <= byteIndex + 1'b1;
            end
            else if (lastWord)
            begin
              state <= Idle;
            end
            else
            begin
              wordAddr <= wordAddr + 1'b1;
              byteIndex <= '0;
              loadPending <= 1'b1;
            end
          end
        end
        default:
        begin
          state <= Idle;
        end
      endcase
    end
  end

  // Keep a copy so a stalled byte 15 survives the prefetch.
  always_ff @(posedge clock)
  begin
    if ((state == Read) || loadPending)
    begin
      wordHeld <= readData;
    end
  end

endmodule

`default_nettype wire

/* source/outputReadout.sv */
`default_nettype none

`include "readout_defs.svh"

module outputReadout
(
  input  logic                               clock,
  input  logic                               reset_n,
  input  logic [`READOUT_AXI_ADDR_WIDTH-1:0] awAddr,
  input  logic                               awValid,
  output logic                               awReady,
  input  logic [31:0]                        wData,
  input  logic [3:0]                         wStrb,
  input  logic                               wValid,
  output logic                               wReady,
  output logic [1:0]                         bResp,
  output logic                               bValid,
  input  logic                               bReady,
  input  logic [`READOUT_AXI_ADDR_WIDTH-1:0] arAddr,
  input  logic                               arValid,
  output logic                               arReady,
  output logic [31:0]                        rData,
  output logic [1:0]                         rResp,
  output logic                               rValid,
  input  logic                               rReady,
  input  logic                               writeEnableA,
  input  readoutPkg::bufAddrT                 writeAddressA,
  input  readoutPkg::wordT                    writeDataA,
  input  logic                               writeEnableB,
  input  readoutPkg::bufAddrT                 writeAddressB,
  input  readoutPkg::wordT                    writeDataB,
  output logic [15:0]                        outData,
  output logic                               outValid,
  output logic                               outLast,
  input  logic                               outReady
);
  import readoutPkg::*;

  logic    runStart;
  lengthT  runLength;
  logic    runDone;
  logic    laneTaken;
  logic    readEnableA;
  logic    readEnableB;
  bufAddrT readAddressA;
  bufAddrT readAddressB;
  wordT    readDataA;
  wordT    readDataB;
  byteT    byteA;
  byteT    byteB;
  logic    validA;
  logic    validB;
  logic    lastA;
  logic    lastB;

  readoutControl u_control
  (
    .clock     (clock),
    .reset_n   (reset_n),
    .awAddr    (awAddr),
    .awValid   (awValid),
    .awReady   (awReady),
    .wData     (wData),
    .wStrb     (wStrb),
    .wValid    (wValid),
    .wReady    (wReady),
    .bResp     (bResp),
    .bValid    (bValid),
    .bReady    (bReady),
    .arAddr    (arAddr),
    .arValid   (arValid),
    .arReady   (arReady),
    .rData     (rData),
    .rResp     (rResp),
    .rValid    (rValid),
    .rReady    (rReady),
    .runStart  (runStart),
    .runLength (runLength),
    .runDone   (runDone)
  );

  resultBuffer u_bufferA
  (
    .clock        (clock),
    .writeEnable  (writeEnableA),
    .writeAddress (writeAddressA),
    .writeData    (writeDataA),
    .readEnable   (readEnableA),
    .readAddress  (readAddressA),
    .readData     (readDataA)
  );

  resultBuffer u_bufferB
  (
    .clock        (clock),
    .writeEnable  (writeEnableB),
    .writeAddress (writeAddressB),
    .writeData    (writeDataB),
    .readEnable   (readEnableB),
    .readAddress  (readAddressB),
    .readData     (readDataB)
  );

  outputFetch u_fetchA
  (
    .clock       (clock),
    .reset_n     (reset_n),
    .runStart    (runStart),
    .runLength   (runLength),
    .readEnable  (readEnableA),
    .readAddress (readAddressA),
    .readData    (readDataA),
    .laneByte    (byteA),
    .laneValid   (validA),
    .laneLast    (lastA),
    .laneTaken   (laneTaken)
  );

  outputFetch u_fetchB
  (
    .clock       (clock),
    .reset_n     (reset_n),
    .runStart    (runStart),
    .runLength   (runLength),
    .readEnable  (readEnableB),
    .readAddress (readAddressB),
    .readData    (readDataB),
    .laneByte    (byteB),
    .laneValid   (validB),
    .laneLast    (lastB),
    .laneTaken   (laneTaken)
  );

  // Lanes run in lockstep on one taken signal.
  bytePairer u_pairer
  (
    .clock     (clock),
    .reset_n   (reset_n),
    .byteA     (byteA),
    .byteB     (byteB),
    .validA    (validA),
    .validB    (validB),
    .lastA     (lastA),
    .lastB     (lastB),
    .laneTaken (laneTaken),
    .outData   (outData),
    .outValid  (outValid),
    .outLast   (outLast),
    .outReady  (outReady),
    .runDone   (runDone)
  );

endmodule

`default_nettype wire

/* source/readoutControl.sv */
`default_nettype none

`include "readout_defs.svh"

module readoutControl
(
  input  logic                               clock,
  input  logic                               reset_n,
  input  logic [`READOUT_AXI_ADDR_WIDTH-1:0] awAddr,
  input  logic                               awValid,
  output logic                               awReady,
  input  logic [31:0]                        wData,
  input  logic [3:0]                         wStrb,
  input  logic                               wValid,
  output logic                               wReady,
  output logic [1:0]                         bResp,
  output logic                               bValid,
  input  logic                               bReady,
  input  logic [`READOUT_AXI_ADDR_WIDTH-1:0] arAddr,
  input  logic                               arValid,
  output logic                               arReady,
  output logic [31:0]                        rData,
  output logic [1:0]                         rResp,
  output logic                               rValid,
  input  logic                               rReady,
  output logic                               runStart,
  output readoutPkg::lengthT                  runLength,
  input  logic                               runDone
);
  import readoutPkg::*;

  logic                               awTaken;
  logic                               wTaken;
  logic [`READOUT_AXI_ADDR_WIDTH-1:0] awAddrHeld;
  logic [31:0]                        wDataHeld;
  logic [3:0]                         wStrbHeld;
  logic                               awFire;
  logic                               wFire;
  logic                               arFire;
  logic                               writeFire;
  logic [`READOUT_AXI_ADDR_WIDTH-1:0] writeOffset;
  logic [`READOUT_AXI_ADDR_WIDTH-1:0] readOffset;
  logic [31:0]                        writeValue;
  logic [3:0]                         writeStrobe;
  logic [31:0]                        readValue;
  logic                               startRequest;
  lengthT                             lengthReg;
  logic                               busy;
  logic                               done;

  assign awFire = awValid && awReady;
  assign wFire = wValid && wReady;
  assign arFire = arValid && arReady;

  // Address and data may come in either order.
  assign writeFire = (awTaken || awFire) && (wTaken || wFire);
  assign writeOffset = awTaken ? awAddrHeld : awAddr;
  assign writeValue = wTaken ? wDataHeld : wData;
  assign writeStrobe = wTaken ? wStrbHeld : wStrb;

  assign startRequest = writeFire && !busy && writeStrobe[0] && writeValue[0] &&
                        ({writeOffset[`READOUT_AXI_ADDR_WIDTH-1:2], 2'b00} == `READOUT_REG_CONTROL);

  assign bResp = 2'b00;
  assign rResp = 2'b00;
  assign runLength = (lengthReg == '0) ? lengthT'(1) : lengthReg;  // Zero runs one word.

  always_ff @(posedge clock)
  begin
    if (awFire)
    begin
      awAddrHeld <= awAddr;
    end
    if (wFire)
    begin
      wDataHeld <= wData;
      wStrbHeld <= wStrb;
    end
  end

  always_ff @(posedge clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      awReady <= 1'b0;
      wReady <= 1'b0;
      awTaken <= 1'b0;
      wTaken <= 1'b0;
      bValid <= 1'b0;
    end
    else
    begin
      awReady <= awValid && !awReady && !awTaken && !bValid;
      wReady <= wValid && !wReady && !wTaken && !bValid;
      if (writeFire)
      begin
        awTaken <= 1'b0;
        wTaken <= 1'b0;
        bValid <= 1'b1;
      end
      else
      begin
        if (awFire)
        begin
          awTaken <= 1'b1;
        end
        if (wFire)
        begin
          wTaken <= 1'b1;
        end
        if (bValid && bReady)
        begin
          bValid <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      lengthReg <= '0;
      busy <= 1'b0;
      done <= 1'b0;
      runStart <= 1'b0;
    end
    else
    begin
      runStart <= startRequest;  // Rises with bValid.
      if (startRequest)
      begin
        busy <= 1'b1;
        done <= 1'b0;
      end
      else if (runDone)
      begin
        busy <= 1'b0;
        done <= 1'b1;
      end
      if (writeFire &&
          ({writeOffset[`READOUT_AXI_ADDR_WIDTH-1:2], 2'b00} == `READOUT_REG_LENGTH))
      begin
        if (writeStrobe[0])
        begin
          lengthReg[7:0] <= writeValue[7:0];
        end
        if (writeStrobe[1])
        begin
          lengthReg[8] <= writeValue[8];
        end
      end
    end
  end

  assign readOffset = {arAddr[`READOUT_AXI_ADDR_WIDTH-1:2], 2'b00};

  always_comb
  begin
    case (readOffset)
      `READOUT_REG_LENGTH: readValue = 32'(lengthReg);
      `READOUT_REG_STATUS: readValue = {30'b0, done, busy};
      default:             readValue = 32'h0;  // Control is write only.
    endcase
  end

  always_ff @(posedge clock or negedge reset_n)
  begin
    if (!reset_n)
    begin
      arReady <= 1'b0;
      rValid <= 1'b0;
    end
    else
    begin
      arReady <= arValid && !arReady && !rValid;
      if (arFire)
      begin
        rValid <= 1'b1;
      end
      else if (rValid && rReady)
      begin
        rValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock)
  begin
    if (arFire)
    begin
      rData <= readValue;
    end
  end

endmodule

`default_nettype wire

/* source/readoutPkg.sv */
`default_nettype none

`include "readout_defs.svh"

package readoutPkg;

  typedef logic [`READOUT_DATA_WIDTH-1:0] wordT;
  typedef logic [`READOUT_ADDR_WIDTH-1:0] bufAddrT;
  typedef logic [`READOUT_BYTE_WIDTH-1:0] byteT;
  typedef logic [`READOUT_LENGTH_WIDTH-1:0] lengthT;  // Words per lane.
  typedef logic [`READOUT_BYTE_INDEX_WIDTH-1:0] byteIndexT;

  // Fetch unit sequencing.
  typedef enum logic [1:0]
  {
    Idle,
    Read,
    Emit
  } fetchStateT;

endpackage

`default_nettype wire

/* source/readout_defs.svh */
`ifndef READOUT_DEFS_SVH
`define READOUT_DEFS_SVH

// Result buffer geometry.
`define READOUT_DATA_WIDTH 128
`define READOUT_ADDR_WIDTH 8
`define READOUT_BUFFER_DEPTH 256

// Serialized byte and its position in a word.
`define READOUT_BYTE_WIDTH 8
`define READOUT_BYTE_INDEX_WIDTH 4

// One extra bit so a full buffer of 256 words fits.
`define READOUT_LENGTH_WIDTH 9

// Host register map.
`define READOUT_AXI_ADDR_WIDTH 4
`define READOUT_REG_CONTROL 4'h0
`define READOUT_REG_LENGTH 4'h4
`define READOUT_REG_STATUS 4'h8

`endif

/* source/resultBuffer.sv */
`default_nettype none

`include "readout_defs.svh"

module resultBuffer
(
  input  logic               clock,
  input  logic               writeEnable,
  input  readoutPkg::bufAddrT writeAddress,
  input  readoutPkg::wordT    writeData,
  input  logic               readEnable,
  input  readoutPkg::bufAddrT readAddress,
  output readoutPkg::wordT    readData
);
  import readoutPkg::*;

  wordT memory [`READOUT_BUFFER_DEPTH];

  always_ff @(posedge clock)
  begin
    if (writeEnable)
    begin
      memory[writeAddress] <= writeData;
    end
  end

  // Output holds its last word while readEnable is low.
  always_ff @(posedge clock)
  begin
    if (readEnable)
    begin
      readData <= memory[readAddress];
    end
  end

endmodule

`default_nettype wire

/* tb/tbOutputReadout.sv */
`default_nettype none

`include "readout_defs.svh"

module tbOutputReadout;
  import readoutPkg::*;

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [1:0] OkayResp = 2'b00;
  localparam int TimeoutCycles = 4000;  // All tests need well under half of this.

  logic                               clock;
  logic                               reset_n;
  logic [`READOUT_AXI_ADDR_WIDTH-1:0] awAddr;
  logic                               awValid;
  logic                               awReady;
  logic [31:0]                        wData;
  logic [3:0]                         wStrb;
  logic                               wValid;
  logic                               wReady;
  logic [1:0]                         bResp;
  logic                               bValid;
  logic                               bReady;
  logic [`READOUT_AXI_ADDR_WIDTH-1:0] arAddr;
  logic                               arValid;
  logic                               arReady;
  logic [31:0]                        rData;
  logic [1:0]                         rResp;
  logic                               rValid;
  logic                               rReady;
  logic                               writeEnableA;
  bufAddrT                            writeAddressA;
  wordT                               writeDataA;
  logic                               writeEnableB;
  bufAddrT                            writeAddressB;
  wordT                               writeDataB;
  logic [15:0]                        outData;
  logic                               outValid;
  logic                               outLast;
  logic                               outReady;

  wordT        memA [`READOUT_BUFFER_DEPTH];  // Reference copies of the buffers.
  wordT        memB [`READOUT_BUFFER_DEPTH];
  logic [16:0] beats[$];  // {outLast, outData}
  time         beatTimes[$];
  int          errorCount;
  int          testCount;
  int          failedTests;
  int          cycleCount;

  outputReadout u_dut
  (
    .clock         (clock),
    .reset_n       (reset_n),
    .awAddr        (awAddr),
    .awValid       (awValid),
    .awReady       (awReady),
    .wData         (wData),
    .wStrb         (wStrb),
    .wValid        (wValid),
    .wReady        (wReady),
    .bResp         (bResp),
    .bValid        (bValid),
    .bReady        (bReady),
    .arAddr        (arAddr),
    .arValid       (arValid),
    .arReady       (arReady),
    .rData         (rData),
    .rResp         (rResp),
    .rValid        (rValid),
    .rReady        (rReady),
    .writeEnableA  (writeEnableA),
    .writeAddressA (writeAddressA),
    .writeDataA    (writeDataA),
    .writeEnableB  (writeEnableB),
    .writeAddressB (writeAddressB),
    .writeDataB    (writeDataB),
    .outData       (outData),
    .outValid      (outValid),
    .outLast       (outLast),
    .outReady      (outReady)
  );

  initial
  begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic axiWrite(input logic [`READOUT_AXI_ADDR_WIDTH-1:0] addr,
                          input logic [31:0] data);
    logic awGo;
    logic wGo;
    logic bGo;
    @(negedge clock);
    awAddr = addr;
    awValid = 1'b1;
    wData = data;
    wStrb = 4'hF;
    wValid = 1'b1;
    bReady = 1'b1;
    bGo = 1'b0;
    while (!bGo)
    begin
      awGo = awValid && awReady;  // Transfers happen on the coming edge.
      wGo = wValid && wReady;
      bGo = bValid && bReady;
      if (bGo && (bResp !== OkayResp))
      begin
        $display("Mismatch at %0t: bResp expected %h actual %h", $time, OkayResp, bResp);
        errorCount++;
      end
      @(negedge clock);
      if (awGo)
      begin
        awValid = 1'b0;
      end
      if (wGo)
      begin
        wValid = 1'b0;
      end
    end
    bReady = 1'b0;
  endtask

  task automatic axiRead(input logic [`READOUT_AXI_ADDR_WIDTH-1:0] addr,
                         output logic [31:0] data);
    logic arGo;
    logic rGo;
    @(negedge clock);
    arAddr = addr;
    arValid = 1'b1;
    rReady = 1'b1;
    rGo = 1'b0;
    data = '0;
    while (!rGo)
    begin
      arGo = arValid && arReady;
      rGo = rValid && rReady;
      if (rGo)
      begin
        data = rData;
        if (rResp !== OkayResp)
        begin
          $display("Mismatch at %0t: rResp expected %h actual %h", $time, OkayResp, rResp);
          errorCount++;
        end
      end
      @(negedge clock);
      if (arGo)
      begin
        arValid = 1'b0;
      end
    end
    rReady = 1'b0;
  endtask

  task automatic expectRead(input logic [`READOUT_AXI_ADDR_WIDTH-1:0] addr,
                            input logic [31:0] expected, input string what);
    logic [31:0] value;
    axiRead(addr, value);
    if (value !== expected)
    begin
      $display("Mismatch at %0t: rData (%s) expected %h actual %h",
               $time, what, expected, value);
      errorCount++;
    end
  endtask

  task automatic loadWord(input bufAddrT addr, input wordT a, input wordT b);
    @(negedge clock);
    writeEnableA = 1'b1;
    writeAddressA = addr;
    writeDataA = a;
    writeEnableB = 1'b1;
    writeAddressB = addr;
    writeDataB = b;
    memA[addr] = a;
    memB[addr] = b;
    @(negedge clock);
    writeEnableA = 1'b0;
    writeEnableB = 1'b0;
  endtask

  function automatic wordT randomWord();
    return {$urandom, $urandom, $urandom, $urandom};
  endfunction

  task automatic loadRandom(input int words);
    int i;
    for (i = 0; i < words; i++)
    begin
      loadWord(bufAddrT'(i), randomWord(), randomWord());
    end
  endtask

  task automatic startRun(input int length);
    axiWrite(`READOUT_REG_LENGTH, 32'(length));
    axiWrite(`READOUT_REG_CONTROL, 32'h1);
  endtask

  // Lane B high, lane A low, bytes in ascending order.
  function automatic logic [15:0] expectedBeat(input int index);
    int w;
    int k;
    w = index / 16;
    k = index % 16;
    return {memB[w][k*8 +: 8], memA[w][k*8 +: 8]};
  endfunction

  task automatic collectBeats(input int count, input int stallPercent);
    beats.delete();
    beatTimes.delete();
    while (beats.size() < count)
    begin
      @(negedge clock);
      if (stallPercent == 0)
      begin
        outReady = 1'b1;
      end
      else
      begin
        outReady = (($urandom % 100) >= stallPercent);
      end
      if (outValid && outReady)
      begin
        beats.push_back({outLast, outData});
        beatTimes.push_back($time);
      end
      else if (outReady && (stallPercent == 0) && (beats.size() > 0))
      begin
        $display("Gap in the output stream after beat %0d at %0t", beats.size(), $time);
        errorCount++;
      end
    end
    @(negedge clock);
    outReady = 1'b0;
    if (outValid)
    begin
      $display("Extra beat: outValid still high after the last beat at %0t", $time);
      errorCount++;
    end
  endtask

  task automatic checkBeats(input int words);
    int i;
    logic [16:0] expected;
    if (beats.size() != words * 16)
    begin
      $display("Mismatch at %0t: beat count expected %0d actual %0d",
               $time, words * 16, beats.size());
      errorCount++;
    end
    for (i = 0; (i < words * 16) && (i < beats.size()); i++)
    begin
      expected = {(i == words * 16 - 1), expectedBeat(i)};
      if (beats[i][15:0] !== expected[15:0])
      begin
        $display("Mismatch at %0t: outData beat %0d expected %h actual %h",
                 beatTimes[i], i, expected[15:0], beats[i][15:0]);
        errorCount++;
      end
      if (beats[i][16] !== expected[16])
      begin
        $display("Mismatch at %0t: outLast beat %0d expected %b actual %b",
                 beatTimes[i], i, expected[16], beats[i][16]);
        errorCount++;
      end
    end
  endtask

  task automatic reportTest(input string name, input int errorsBefore);
    testCount++;
    if (errorCount == errorsBefore)
    begin
      $display("%s: ok", name);
    end
    else
    begin
      failedTests++;
      $display("%s: FAILED with %0d errors", name, errorCount - errorsBefore);
    end
  endtask

  task automatic checkResetAndRegisters();
    int errorsBefore;
    errorsBefore = errorCount;
    if (outValid !== 1'b0)
    begin
      $display("Mismatch at %0t: outValid expected 0 actual %b", $time, outValid);
      errorCount++;
    end
    expectRead(`READOUT_REG_STATUS, 32'h0, "STATUS after reset");
    axiWrite(`READOUT_REG_LENGTH, 32'd5);
    expectRead(`READOUT_REG_LENGTH, 32'd5, "LENGTH");
    expectRead(4'hC, 32'h0, "unmapped offset");
    reportTest("reset and registers", errorsBefore);
  endtask

  task automatic checkSingleWordRun();
    int errorsBefore;
    int k;
    wordT wordA;
    wordT wordB;
    errorsBefore = errorCount;
    for (k = 0; k < 16; k++)
    begin
      wordA[k*8 +: 8] = 8'(k);
      wordB[k*8 +: 8] = 8'(8'h80 | k);
    end
    loadWord('0, wordA, wordB);
    startRun(1);
    collectBeats(16, 0);
    checkBeats(1);
    if ((beats.size() == 16) && (beats[15] !== {1'b1, 16'h8f0f}))
    begin
      $display("Mismatch at %0t: final beat expected %h actual %h",
               beatTimes[15], {1'b1, 16'h8f0f}, beats[15]);
      errorCount++;
    end
    reportTest("single word run", errorsBefore);
  endtask

  task automatic checkFourWordRun();
    int errorsBefore;
    errorsBefore = errorCount;
    loadRandom(4);
    startRun(4);
    collectBeats(64, 0);
    checkBeats(4);
    reportTest("four word run", errorsBefore);
  endtask

  task automatic checkStalledRun();
    int errorsBefore;
    errorsBefore = errorCount;
    loadRandom(3);
    startRun(3);
    collectBeats(48, 0);
    checkBeats(3);
    startRun(3);
    collectBeats(48, 40);
    checkBeats(3);
    reportTest("stalled run", errorsBefore);
  endtask

  task automatic checkBusyAndDone();
    int errorsBefore;
    errorsBefore = errorCount;
    loadRandom(2);
    startRun(2);  // Output held back so the run stays busy.
    expectRead(`READOUT_REG_STATUS, 32'h1, "STATUS while busy");
    axiWrite(`READOUT_REG_CONTROL, 32'h1);
    collectBeats(32, 0);
    checkBeats(2);
    expectRead(`READOUT_REG_STATUS, 32'h2, "STATUS after run");
    startRun(1);
    expectRead(`READOUT_REG_STATUS, 32'h1, "STATUS after restart");
    collectBeats(16, 0);
    checkBeats(1);
    expectRead(`READOUT_REG_STATUS, 32'h2, "STATUS after second run");
    reportTest("busy and done", errorsBefore);
  endtask

  task automatic checkZeroLength();
    int errorsBefore;
    errorsBefore = errorCount;
    loadRandom(1);
    startRun(0);
    collectBeats(16, 0);
    checkBeats(1);
    reportTest("zero length", errorsBefore);
  endtask

  initial
  begin
    reset_n = 1'b0;
    awAddr = '0;
    awValid = 1'b0;
    wData = '0;
    wStrb = '0;
    wValid = 1'b0;
    bReady = 1'b0;
    arAddr = '0;
    arValid = 1'b0;
    rReady = 1'b0;
    writeEnableA = 1'b0;
    writeAddressA = '0;
    writeDataA = '0;
    writeEnableB = 1'b0;
    writeAddressB = '0;
    writeDataB = '0;
    outReady = 1'b0;
    errorCount = 0;
    testCount = 0;
    failedTests = 0;
    void'($urandom(65));
    repeat (8) @(posedge clock);
    @(negedge clock);
    reset_n = 1'b1;
    checkResetAndRegisters();
    checkSingleWordRun();
    checkFourWordRun();
    checkStalledRun();
    checkBusyAndDone();
    checkZeroLength();
    $display("Summary: %0d tests, %0d failing, %0d errors", testCount, failedTests, errorCount);
    if (errorCount == 0)
    begin
      $display("Test passed");
    end
    else
    begin
      $display("Test failed");
    end
    $finish;
  end

  initial
  begin
    cycleCount = 0;
    while (cycleCount < TimeoutCycles)
    begin
      @(posedge clock);
      cycleCount++;
    end
    $display("Timeout after %0d cycles, the tests did not complete", cycleCount);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire
